// ==== include/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// External memory content seen by the responder
function automatic logic [n_storage-1:0] mem_word(input int addr);
    return n_storage'(addr) ^ 16'h5a00;
endfunction

function automatic int total_param_words();
    int n;
    n = 0;
    for (int l = 0; l < num_param_layers; l++) begin
        n += int'(layer_len[l]) * int'(layer_num_rec[l]);
    end
    return n;
endfunction

function automatic int total_broadcasts();
    int n;
    n = num_inf_steps;
    for (int s = 0; s < num_inf_steps; s++) begin
        n += int'(step_num_cim[s]);
    end
    return n;
endfunction

// Upper sample bits in word 0, the other words zero
function automatic bus_payload_t patch_payload(input logic [eeg_sample_depth-1:0] sample);
    bus_payload_t p;
    p = '0;
    p.words[0] = n_storage'(sample >> (eeg_sample_depth - q_bits));
    return p;
endfunction

task automatic expect_instr(input logic [bus_op_width-1:0] op, input int target,
                            input bus_payload_t data);
    exp_op.push_back(op);
    exp_target.push_back(cim_id_width'(target));
    exp_data.push_back(data);
endtask

// One START per record, then three memory words per stream instruction
task automatic model_param_load();
    bus_payload_t p;
    int addr;
    addr = 0;
    for (int l = 0; l < num_param_layers; l++) begin
        for (int r = 0; r < int'(layer_num_rec[l]); r++) begin
            p = '0;
            p.fields.addr = layer_cim_addr[l];
            p.fields.len  = layer_len[l];
            expect_instr(PARAM_STREAM_START_OP, r, p);
            for (int w = 0; w < int'(layer_len[l]); w += 3) begin
                for (int k = 0; k < 3; k++) begin
                    p.words[k] = mem_word(addr + k);
                end
                expect_instr(PARAM_STREAM_OP, r, p);
                addr += 3;
            end
        end
    end
endtask

// Each CiM of a step in turn, then the pistol to CiM 0
task automatic model_inference();
    bus_payload_t p;
    for (int s = 0; s < num_inf_steps; s++) begin
        p = '0;
        p.fields.addr    = step_tx_addr[s];
        p.fields.len     = step_len[s];
        p.fields.rx_addr = step_rx_addr[s];
        for (int c = 0; c < int'(step_num_cim[s]); c++) begin
            expect_instr(step_op[s], c, p);
        end
        expect_instr(PISTOL_START_OP, 0, p);
    end
endtask

`endif

// ==== bench/tb_cim_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cim_master import cim_master_pkg::*; ();

    localparam int clk_half      = 20;
    localparam int drive_delay   = 2;
    localparam int max_mem_delay = 4;
    localparam int num_samples   = 12;
    localparam logic [31:0] lcg_seed = 32'hfad3_0ac3;

    logic                          clk;
    logic                          rst_n;
    logic                          start_param_load;
    logic                          new_sleep_epoch;
    logic                          new_eeg_sample;
    logic [eeg_sample_depth-1:0]   eeg_sample;
    logic                          all_cims_ready;
    logic [bus_op_width-1:0]       bus_op_in;
    logic                          ext_mem_data_valid;
    logic signed [n_storage-1:0]   ext_mem_data;
    logic                          bus_drive;
    logic [bus_op_width-1:0]       bus_op;
    bus_payload_t                  bus_data;
    logic [cim_id_width-1:0]       bus_target;
    logic [ext_mem_addr_width-1:0] ext_mem_addr;
    logic                          ext_mem_read_pulse;
    logic                          inference_done;

    // Expected instructions in issue order
    logic [bus_op_width-1:0] exp_op[$];
    logic [cim_id_width-1:0] exp_target[$];
    bus_payload_t            exp_data[$];

    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          read_count;
    int          read_addr_exp;
    int          read_addr;
    int          read_wait;
    int          done_count;
    int          pistol_count;
    logic        read_pending;
    logic        result_mode;
    logic        sample_d;
    logic        idle_d1;
    logic        idle_d2;
    logic [31:0] mem_rng;
    logic [31:0] rdy_rng;
    logic [31:0] stim_rng;

    `include "tb_model.svh"

    cim_master u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_value(input string name, input logic [63:0] got,
                                input logic [63:0] want);
        $display("FAIL %s got %0h expected %0h at %0t", name, got, want, $time);
        errors++;
    endtask

    task automatic report_error(input string what);
        $display("error: %s at %0t", what, $time);
        errors++;
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != test_errors) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - test_errors);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #drive_delay;
    endtask

    // Compare one issued instruction with the head of the model
    task automatic check_issue();
        assert (exp_op.size() > 0) else report_error("instruction issued beyond the model");
        if (exp_op.size() > 0) begin
            assert (bus_op == exp_op[0]) else report_value("bus_op", bus_op, exp_op[0]);
            assert (bus_target == exp_target[0])
            else report_value("bus_target", bus_target, exp_target[0]);
            assert (bus_data == exp_data[0]) else report_value("bus_data", bus_data, exp_data[0]);
            if (bus_op inside {DENSE_BROADCAST_OP, TRANS_BROADCAST_OP, PISTOL_START_OP}) begin
                assert (idle_d2) else report_error("broadcast issued while the bus was busy");
            end
            void'(exp_op.pop_front());
            void'(exp_target.pop_front());
            void'(exp_data.pop_front());
        end
    endtask

    task automatic run_param_load(input string name);
        begin_test();
        model_param_load();
        read_addr_exp = 0;
        read_count    = 0;
        start_param_load = 1'b1;
        step();
        start_param_load = 1'b0;
        step();
        while (exp_op.size() != 0 || bus_drive) begin
            step();
        end
        assert (read_count == total_param_words())
        else report_value("ext_mem_read_pulse count", read_count, total_param_words());
        assert (!read_pending) else report_error("memory read still pending at the end");
        end_test(name);
    endtask

    // Bus monitor
    always @(posedge clk) begin
        if (rst_n) begin
            if (sample_d) begin
                assert (bus_drive && bus_op == PATCH_LOAD_BROADCAST_OP)
                else report_error("no patch load broadcast one cycle after a new sample");
            end
            if (bus_drive && bus_op != NOP) begin
                check_issue();
            end
            if (inference_done) begin
                done_count++;
            end
        end
        sample_d = rst_n && new_eeg_sample;
        idle_d2  = idle_d1;
        idle_d1  = all_cims_ready && (bus_op_in == NOP);
    end

    // External memory with a random latency per read
    always @(posedge clk) begin
        if (ext_mem_data_valid) begin
            read_pending = 1'b0;
        end
        if (rst_n && ext_mem_read_pulse) begin
            assert (!read_pending) else report_error("read pulse before the previous answer");
            assert (ext_mem_addr == ext_mem_addr_width'(read_addr_exp))
            else report_value("ext_mem_addr", ext_mem_addr, read_addr_exp);
            read_pending = 1'b1;
            read_addr    = int'(ext_mem_addr);
            read_addr_exp++;
            read_count++;
            mem_rng   = lcg(mem_rng);
            read_wait = 1 + int'(mem_rng[17:16]);
        end
        #drive_delay;
        ext_mem_data_valid = 1'b0;
        if (read_pending && read_wait > 0) begin
            read_wait--;
            if (read_wait == 0) begin
                ext_mem_data_valid = 1'b1;
                ext_mem_data       = mem_word(read_addr);
            end
        end
    end

    // CiM side, answers with the result after the last pistol
    always @(posedge clk) begin
        if (rst_n && bus_drive && bus_op == PISTOL_START_OP) begin
            pistol_count++;
            if (pistol_count == num_inf_steps) begin
                result_mode  = 1'b1;
                pistol_count = 0;
            end
        end
        if (inference_done) begin
            result_mode = 1'b0;
        end
        #drive_delay;
        rdy_rng        = lcg(rdy_rng);
        all_cims_ready = (rdy_rng[17:16] != 2'b00);
        if (result_mode) begin
            bus_op_in = INFERENCE_RESULT_OP;
        end else if (rdy_rng[19:18] == 2'b00) begin
            // A CiM still driving the bus now and then
            bus_op_in = DENSE_BROADCAST_OP;
        end else begin
            bus_op_in = NOP;
        end
    end

    initial begin
        int limit;
        limit = (2 * total_param_words() + total_broadcasts() + num_samples)
                * max_mem_delay * 4 + 200;
        repeat (limit) @(posedge clk);
        $display("error: watchdog expired after %0d cycles", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n              = 1'b0;
        start_param_load   = 1'b0;
        new_sleep_epoch    = 1'b0;
        new_eeg_sample     = 1'b0;
        eeg_sample         = '0;
        all_cims_ready     = 1'b0;
        bus_op_in          = NOP;
        ext_mem_data_valid = 1'b0;
        ext_mem_data       = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        read_count   = 0;
        read_wait    = 0;
        done_count   = 0;
        pistol_count = 0;
        read_pending = 1'b0;
        result_mode  = 1'b0;
        sample_d     = 1'b0;
        idle_d1      = 1'b0;
        idle_d2      = 1'b0;
        mem_rng      = lcg_seed;
        rdy_rng      = lcg_seed ^ 32'h0000_ffff;
        stim_rng     = lcg_seed ^ 32'hffff_0000;

        begin_test();
        repeat (4) @(posedge clk);
        #drive_delay;
        assert (!bus_drive) else report_value("bus_drive", bus_drive, 0);
        assert (!ext_mem_read_pulse) else report_value("ext_mem_read_pulse", ext_mem_read_pulse, 0);
        assert (!inference_done) else report_value("inference_done", inference_done, 0);
        assert (bus_op == NOP) else report_value("bus_op", bus_op, NOP);
        rst_n = 1'b1;
        step();
        end_test("reset_state");

        run_param_load("param_load");

        begin_test();
        expect_instr(PATCH_LOAD_BROADCAST_START_OP, 0, '0);
        new_sleep_epoch = 1'b1;
        step();
        for (int i = 0; i < num_samples; i++) begin
            stim_rng       = lcg(stim_rng);
            eeg_sample     = stim_rng[31:16];
            new_eeg_sample = 1'b1;
            expect_instr(PATCH_LOAD_BROADCAST_OP, 0, patch_payload(eeg_sample));
            step();
            new_eeg_sample = 1'b0;
            stim_rng = lcg(stim_rng);
            repeat (1 + int'(stim_rng[17:16])) step();
        end
        while (exp_op.size() != 0) begin
            step();
        end
        end_test("signal_load");

        // Falling epoch starts the inference
        begin_test();
        done_count = 0;
        model_inference();
        new_sleep_epoch = 1'b0;
        step();
        while (exp_op.size() != 0 || done_count == 0) begin
            step();
        end
        repeat (3) step();
        assert (done_count == 1) else report_value("inference_done pulses", done_count, 1);
        end_test("inference");

        run_param_load("param_reload");

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cim_master.f ====
+incdir+include
verilog/cim_master_pkg.sv
verilog/master_ctrl.sv
verilog/param_streamer.sv
verilog/broadcast_sequencer.sv
verilog/cim_master.sv
bench/tb_cim_master.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_cim_master -f cim_master.f
./obj_dir/Vtb_cim_master > sim.log
cat sim.log
if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== verilog/broadcast_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module broadcast_sequencer import cim_master_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    bs_start,
    input  logic                    bs_run,
    input  logic                    all_cims_ready,
    input  logic [bus_op_width-1:0] bus_op_in,
    output logic [bus_op_width-1:0] bs_op,
    output bus_payload_t            bs_payload,
    output logic [cim_id_width-1:0] bs_target,
    output logic                    bs_issue,
    output logic                    bs_done
);

    logic [state_width-1:0]    state;
    logic [step_idx_width-1:0] step_cnt;
    // One bit wider so it can reach step_num_cim
    logic [cim_id_width:0]     cim_cnt;
    logic                      bus_idle;

    assign bus_idle = all_cims_ready && (bus_op_in == NOP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= bs_st_idle;
            step_cnt <= '0;
            cim_cnt  <= '0;
        end else begin
            case (state)
                bs_st_idle: begin
                    if (bs_start) begin
                        state    <= bs_st_wait;
                        step_cnt <= '0;
                        cim_cnt  <= '0;
                    end
                end
                bs_st_wait: begin
                    // Bus checked again before every broadcast
                    if (bs_run && bus_idle) begin
                        if (cim_cnt == step_num_cim[step_cnt]) begin
                            state <= bs_st_pistol;
                        end else begin
                            state <= bs_st_send;
                        end
                    end
                end
                bs_st_send: begin
                    cim_cnt <= cim_cnt + 1'b1;
                    state   <= bs_st_wait;
                end
                bs_st_pistol: begin
                    cim_cnt <= '0;
                    if (step_cnt == step_idx_width'(num_inf_steps - 1)) begin
                        state <= bs_st_done;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                        state    <= bs_st_wait;
                    end
                end
                bs_st_done: state <= bs_st_idle;
                default:    state <= bs_st_idle;
            endcase
        end
    end

    always_comb begin
        bs_payload                = '0;
        bs_payload.fields.addr    = step_tx_addr[step_cnt];
        bs_payload.fields.len     = step_len[step_cnt];
        bs_payload.fields.rx_addr = step_rx_addr[step_cnt];
    end

    assign bs_op     = (state == bs_st_pistol) ? PISTOL_START_OP : step_op[step_cnt];
    assign bs_target = (state == bs_st_send) ? cim_cnt[cim_id_width-1:0] : '0;
    assign bs_issue  = (state == bs_st_send) || (state == bs_st_pistol);
    assign bs_done   = (state == bs_st_done);

endmodule

`default_nettype wire

// ==== verilog/cim_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module cim_master import cim_master_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_param_load,
    input  logic                          new_sleep_epoch,
    input  logic                          new_eeg_sample,
    input  logic [eeg_sample_depth-1:0]   eeg_sample,
    input  logic                          all_cims_ready,
    input  logic [bus_op_width-1:0]       bus_op_in,
    input  logic                          ext_mem_data_valid,
    input  logic signed [n_storage-1:0]   ext_mem_data,
    output logic                          bus_drive,
    output logic [bus_op_width-1:0]       bus_op,
    output bus_payload_t                  bus_data,
    output logic [cim_id_width-1:0]       bus_target,
    output logic [ext_mem_addr_width-1:0] ext_mem_addr,
    output logic                          ext_mem_read_pulse,
    output logic                          inference_done
);

    // Parameter load datapath
    logic [bus_op_width-1:0] ps_op;
    bus_payload_t            ps_payload;
    logic [cim_id_width-1:0] ps_target;
    logic                    ps_issue;
    logic                    ps_done;
    logic                    ps_start;

    // Inference datapath
    logic [bus_op_width-1:0] bs_op;
    bus_payload_t            bs_payload;
    logic [cim_id_width-1:0] bs_target;
    logic                    bs_issue;
    logic                    bs_done;
    logic                    bs_start;
    logic                    bs_run;

    master_ctrl u_master_ctrl (
        .clk(clk), .rst_n(rst_n),
        .start_param_load(start_param_load), .new_sleep_epoch(new_sleep_epoch),
        .new_eeg_sample(new_eeg_sample), .eeg_sample(eeg_sample),
        .all_cims_ready(all_cims_ready), .bus_op_in(bus_op_in),
        .ps_op(ps_op), .ps_payload(ps_payload), .ps_target(ps_target),
        .ps_issue(ps_issue), .ps_done(ps_done),
        .bs_op(bs_op), .bs_payload(bs_payload), .bs_target(bs_target),
        .bs_issue(bs_issue), .bs_done(bs_done),
        .ps_start(ps_start), .bs_start(bs_start), .bs_run(bs_run),
        .bus_drive(bus_drive), .bus_op(bus_op), .bus_data(bus_data),
        .bus_target(bus_target), .inference_done(inference_done)
    );

    param_streamer u_param_streamer (
        .clk(clk), .rst_n(rst_n), .ps_start(ps_start),
        .ext_mem_data_valid(ext_mem_data_valid), .ext_mem_data(ext_mem_data),
        .ext_mem_addr(ext_mem_addr), .ext_mem_read_pulse(ext_mem_read_pulse),
        .ps_op(ps_op), .ps_payload(ps_payload), .ps_target(ps_target),
        .ps_issue(ps_issue), .ps_done(ps_done)
    );

    broadcast_sequencer u_broadcast_sequencer (
        .clk(clk), .rst_n(rst_n), .bs_start(bs_start), .bs_run(bs_run),
        .all_cims_ready(all_cims_ready), .bus_op_in(bus_op_in),
        .bs_op(bs_op), .bs_payload(bs_payload), .bs_target(bs_target),
        .bs_issue(bs_issue), .bs_done(bs_done)
    );

endmodule

`default_nettype wire

// ==== verilog/cim_master_pkg.sv ====
`default_nettype none

package cim_master_pkg;

    // Bus and datapath widths
    localparam int n_storage          = 16;
    localparam int bus_op_width       = 4;
    localparam int num_cims           = 8;
    localparam int cim_id_width       = $clog2(num_cims);
    localparam int ext_mem_addr_width = 10;
    localparam int eeg_sample_depth   = 16;
    // Upper sample bits kept, a cheap normalization to fixed point
    localparam int q_bits             = 10;

    // Bus opcodes
    localparam logic [bus_op_width-1:0] NOP                           = 4'd0;
    localparam logic [bus_op_width-1:0] PATCH_LOAD_BROADCAST_START_OP = 4'd1;
    localparam logic [bus_op_width-1:0] PATCH_LOAD_BROADCAST_OP       = 4'd2;
    localparam logic [bus_op_width-1:0] PARAM_STREAM_START_OP         = 4'd3;
    localparam logic [bus_op_width-1:0] PARAM_STREAM_OP               = 4'd4;
    localparam logic [bus_op_width-1:0] DENSE_BROADCAST_OP            = 4'd5;
    localparam logic [bus_op_width-1:0] TRANS_BROADCAST_OP            = 4'd6;
    localparam logic [bus_op_width-1:0] PISTOL_START_OP               = 4'd7;
    localparam logic [bus_op_width-1:0] INFERENCE_RESULT_OP           = 4'd8;

    // Parameter layers, records packed back to back in external memory
    localparam int num_param_layers = 3;
    localparam int layer_idx_width  = $clog2(num_param_layers);
    localparam logic [n_storage-1:0] layer_cim_addr [num_param_layers] =
        '{16'd0, 16'd64, 16'd128};
    // Always a multiple of 3 words
    localparam logic [n_storage-1:0] layer_len [num_param_layers] =
        '{16'd12, 16'd6, 16'd9};
    localparam logic [cim_id_width:0] layer_num_rec [num_param_layers] =
        '{4'd8, 4'd4, 4'd2};

    // Inference steps
    localparam int num_inf_steps  = 4;
    localparam int step_idx_width = $clog2(num_inf_steps);
    localparam logic [bus_op_width-1:0] step_op [num_inf_steps] =
        '{TRANS_BROADCAST_OP, DENSE_BROADCAST_OP, TRANS_BROADCAST_OP, DENSE_BROADCAST_OP};
    localparam logic [n_storage-1:0] step_tx_addr [num_inf_steps] =
        '{16'd0, 16'd128, 16'd256, 16'd320};
    localparam logic [n_storage-1:0] step_rx_addr [num_inf_steps] =
        '{16'd64, 16'd192, 16'd288, 16'd352};
    localparam logic [n_storage-1:0] step_len [num_inf_steps] =
        '{16'd12, 16'd8, 16'd16, 16'd4};
    localparam logic [cim_id_width:0] step_num_cim [num_inf_steps] =
        '{4'd8, 4'd8, 4'd4, 4'd2};

    // State encodings
    localparam int state_width = 3;
    localparam logic [state_width-1:0] st_idle        = 3'd0;
    localparam logic [state_width-1:0] st_param_load  = 3'd1;
    localparam logic [state_width-1:0] st_signal_load = 3'd2;
    localparam logic [state_width-1:0] st_inference   = 3'd3;
    localparam logic [state_width-1:0] st_done        = 3'd4;

    localparam logic [state_width-1:0] ps_st_idle = 3'd0;
    localparam logic [state_width-1:0] ps_st_hdr  = 3'd1;
    localparam logic [state_width-1:0] ps_st_read = 3'd2;
    localparam logic [state_width-1:0] ps_st_wait = 3'd3;
    localparam logic [state_width-1:0] ps_st_send = 3'd4;
    localparam logic [state_width-1:0] ps_st_done = 3'd5;

    localparam logic [state_width-1:0] bs_st_idle   = 3'd0;
    localparam logic [state_width-1:0] bs_st_wait   = 3'd1;
    localparam logic [state_width-1:0] bs_st_send   = 3'd2;
    localparam logic [state_width-1:0] bs_st_pistol = 3'd3;
    localparam logic [state_width-1:0] bs_st_done   = 3'd4;

    // Word 0 overlays addr, word 2 overlays rx_addr
    typedef union packed {
        logic signed [2:0][n_storage-1:0] words;
        struct packed {
            logic [n_storage-1:0] rx_addr;
            logic [n_storage-1:0] len;
            logic [n_storage-1:0] addr;
        } fields;
    } bus_payload_t;

endpackage

`default_nettype wire

// ==== verilog/master_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module master_ctrl import cim_master_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start_param_load,
    input  logic                          new_sleep_epoch,
    input  logic                          new_eeg_sample,
    input  logic [eeg_sample_depth-1:0]   eeg_sample,
    input  logic                          all_cims_ready,
    input  logic [bus_op_width-1:0]       bus_op_in,
    input  logic [bus_op_width-1:0]       ps_op,
    input  bus_payload_t                  ps_payload,
    input  logic [cim_id_width-1:0]       ps_target,
    input  logic                          ps_issue,
    input  logic                          ps_done,
    input  logic [bus_op_width-1:0]       bs_op,
    input  bus_payload_t                  bs_payload,
    input  logic [cim_id_width-1:0]       bs_target,
    input  logic                          bs_issue,
    input  logic                          bs_done,
    output logic                          ps_start,
    output logic                          bs_start,
    output logic                          bs_run,
    output logic                          bus_drive,
    output logic [bus_op_width-1:0]       bus_op,
    output bus_payload_t                  bus_data,
    output logic [cim_id_width-1:0]       bus_target,
    output logic                          inference_done
);

    logic [state_width-1:0] state;
    logic                   bs_finished;
    bus_payload_t           patch_payload;

    // Upper bits of the sample in word 0, rest zero
    always_comb begin
        patch_payload = '0;
        patch_payload.words[0] = {{(n_storage-q_bits){1'b0}},
                                  eeg_sample[eeg_sample_depth-1 -: q_bits]};
    end

    assign bs_run         = (state == st_inference);
    assign inference_done = (state == st_done);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= st_idle;
            ps_start    <= 1'b0;
            bs_start    <= 1'b0;
            bs_finished <= 1'b0;
            bus_drive   <= 1'b0;
            bus_op      <= NOP;
        end else begin
            ps_start <= 1'b0;
            bs_start <= 1'b0;
            case (state)
                st_idle: begin
                    bus_drive   <= 1'b0;
                    bus_op      <= NOP;
                    bs_finished <= 1'b0;
                    if (start_param_load) begin
                        state     <= st_param_load;
                        ps_start  <= 1'b1;
                        bus_drive <= 1'b1;
                    end else if (new_sleep_epoch) begin
                        state     <= st_signal_load;
                        bus_drive <= 1'b1;
                        bus_op    <= PATCH_LOAD_BROADCAST_START_OP;
                    end
                end
                st_param_load: begin
                    // Bus stays driven, NOP while memory reads are pending
                    bus_op <= ps_issue ? ps_op : NOP;
                    if (ps_done) begin
                        state     <= st_idle;
                        bus_drive <= 1'b0;
                    end
                end
                st_signal_load: begin
                    bus_op    <= new_eeg_sample ? PATCH_LOAD_BROADCAST_OP : NOP;
                    bus_drive <= new_sleep_epoch;
                    if (!new_sleep_epoch) begin
                        state    <= st_inference;
                        bs_start <= 1'b1;
                    end
                end
                st_inference: begin
                    bus_drive <= bs_issue;
                    bus_op    <= bs_issue ? bs_op : NOP;
                    if (bs_done) begin
                        bs_finished <= 1'b1;
                    end
                    // Result only counts once every step has been broadcast
                    if (all_cims_ready && (bus_op_in == INFERENCE_RESULT_OP) &&
                        (bs_done || bs_finished)) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    bus_drive <= 1'b0;
                    bus_op    <= NOP;
                    state     <= st_idle;
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Payload and target follow the source of the current state
    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                bus_data   <= '0;
                bus_target <= '0;
            end
            st_param_load: begin
                if (ps_issue) begin
                    bus_data   <= ps_payload;
                    bus_target <= ps_target;
                end
            end
            st_signal_load: begin
                if (new_eeg_sample) begin
                    bus_data   <= patch_payload;
                    bus_target <= '0;
                end
            end
            st_inference: begin
                if (bs_issue) begin
                    bus_data   <= bs_payload;
                    bus_target <= bs_target;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/param_streamer.sv ====
`timescale 1ns/1ps
`default_nettype none

module param_streamer import cim_master_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          ps_start,
    input  logic                          ext_mem_data_valid,
    input  logic signed [n_storage-1:0]   ext_mem_data,
    output logic [ext_mem_addr_width-1:0] ext_mem_addr,
    output logic                          ext_mem_read_pulse,
    output logic [bus_op_width-1:0]       ps_op,
    output bus_payload_t                  ps_payload,
    output logic [cim_id_width-1:0]       ps_target,
    output logic                          ps_issue,
    output logic                          ps_done
);

    logic [state_width-1:0]        state;
    logic [1:0]                    word_cnt;
    logic [n_storage-1:0]          rec_word_cnt;
    logic [cim_id_width-1:0]       rec_cnt;
    logic [layer_idx_width-1:0]    layer_cnt;
    logic [ext_mem_addr_width-1:0] mem_addr;
    bus_payload_t                  word_buf;
    logic                          last_rec;
    logic                          last_layer;

    assign last_rec   = ({1'b0, rec_cnt} == layer_num_rec[layer_cnt] - 1'b1);
    assign last_layer = (layer_cnt == layer_idx_width'(num_param_layers - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= ps_st_idle;
            word_cnt     <= '0;
            rec_word_cnt <= '0;
            rec_cnt      <= '0;
            layer_cnt    <= '0;
            mem_addr     <= '0;
        end else begin
            case (state)
                ps_st_idle: begin
                    if (ps_start) begin
                        state        <= ps_st_hdr;
                        word_cnt     <= '0;
                        rec_word_cnt <= '0;
                        rec_cnt      <= '0;
                        layer_cnt    <= '0;
                        mem_addr     <= '0;
                    end
                end
                ps_st_hdr:  state <= ps_st_read;
                ps_st_read: state <= ps_st_wait;
                ps_st_wait: begin
                    // Address is held until the memory answers
                    if (ext_mem_data_valid) begin
                        mem_addr     <= mem_addr + 1'b1;
                        rec_word_cnt <= rec_word_cnt + 1'b1;
                        if (word_cnt == 2'd2) begin
                            word_cnt <= '0;
                            state    <= ps_st_send;
                        end else begin
                            word_cnt <= word_cnt + 1'b1;
                            state    <= ps_st_read;
                        end
                    end
                end
                ps_st_send: begin
                    if (rec_word_cnt != layer_len[layer_cnt]) begin
                        state <= ps_st_read;
                    end else if (!last_rec) begin
                        rec_cnt      <= rec_cnt + 1'b1;
                        rec_word_cnt <= '0;
                        state        <= ps_st_hdr;
                    end else if (!last_layer) begin
                        layer_cnt    <= layer_cnt + 1'b1;
                        rec_cnt      <= '0;
                        rec_word_cnt <= '0;
                        state        <= ps_st_hdr;
                    end else begin
                        state <= ps_st_done;
                    end
                end
                ps_st_done: state <= ps_st_idle;
                default:    state <= ps_st_idle;
            endcase
        end
    end

    // Three memory words per stream instruction
    always_ff @(posedge clk) begin
        if ((state == ps_st_wait) && ext_mem_data_valid) begin
            word_buf.words[word_cnt] <= ext_mem_data;
        end
    end

    always_comb begin
        ps_op      = PARAM_STREAM_OP;
        ps_payload = word_buf;
        if (state == ps_st_hdr) begin
            ps_op                     = PARAM_STREAM_START_OP;
            ps_payload.fields.addr    = layer_cim_addr[layer_cnt];
            ps_payload.fields.len     = layer_len[layer_cnt];
            ps_payload.fields.rx_addr = '0;
        end
    end

    assign ps_issue           = (state == ps_st_hdr) || (state == ps_st_send);
    assign ps_target          = rec_cnt;
    assign ps_done            = (state == ps_st_done);
    assign ext_mem_read_pulse = (state == ps_st_read);
    assign ext_mem_addr       = mem_addr;

endmodule

`default_nettype wire
